// ==== logic/blit_cfg.svh ====
/* Blit engine constants
 * Bus widths, device IDs, credit count and register map
 */
`ifndef BLIT_CFG_SVH
`define BLIT_CFG_SVH

`define BLIT_ADDR_W        31
`define BLIT_DATA_W        64
`define BLIT_MASK_W        8
`define BLIT_LEN_W         4
`define BLIT_DID           4'h2
`define BLIT_SUBDID        4'h1
`define BLIT_CREDITS_W     3
`define BLIT_INIT_CREDITS  4
`define BLIT_BURST         8

// Register offsets, low five address bits
`define BLIT_REG_RDADDR    5'h00
`define BLIT_REG_RDLEN     5'h04
`define BLIT_REG_WRADDR    5'h08
`define BLIT_REG_WRROWL    5'h0C
`define BLIT_REG_WRROWS    5'h10
`define BLIT_REG_WRDONE    5'h14

`define BLIT_CFG_PFX       24'h100000
`define BLIT_CFG_MASK      24'hF00000

`endif

// ==== logic/blit_pkg.sv ====
/* Shared blit engine types
 * Memory bus request mode, sequencer states, address and data words
 */
`include "blit_cfg.svh"

package blit_pkg;

	typedef enum logic {
		fsab_read  = 1'b0,
		fsab_write = 1'b1
	} fsab_mode_t;

	// One packet in flight, read side then write side
	typedef enum logic [2:0] {
		seq_idle,
		seq_rd_req,
		seq_rd_wait,
		seq_wr_req,
		seq_wr_burst
	} seq_state_t;

	typedef logic [`BLIT_ADDR_W-1:0] blit_addr_t;

	typedef logic [`BLIT_DATA_W-1:0] blit_word_t;

endpackage

// ==== logic/blit_regs.sv ====
/* blit_regs: register bus slave
 * Prefix and offset decode, row length and stride registers,
 * write strobes and WRDONE readback
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module blit_regs (
	input  logic                fsabi_clk,
	input  logic                fsabi_rst_b,
	input  logic                cfg_valid,
	input  logic                cfg_r_nw,
	input  logic [23:0]         cfg_addr,
	input  logic [31:0]         cfg_wdata,
	input  blit_pkg::blit_addr_t wr_done,
	output logic                cfg_done,
	output logic [31:0]         cfg_rdata,
	output logic                strb_rdaddr,
	output logic                strb_rdlen,
	output logic                strb_wrcur,
	output blit_pkg::blit_addr_t row_len,
	output blit_pkg::blit_addr_t row_stride
);

	logic       hit;
	logic       wr_hit;
	logic       rd_hit;
	logic [4:0] offset;

	assign hit    = cfg_valid && ((cfg_addr & `BLIT_CFG_MASK) == `BLIT_CFG_PFX);
	assign wr_hit = hit && !cfg_r_nw;
	assign rd_hit = hit && cfg_r_nw;
	assign offset = cfg_addr[4:0];

	assign strb_rdaddr = wr_hit && (offset == `BLIT_REG_RDADDR);
	assign strb_rdlen  = wr_hit && (offset == `BLIT_REG_RDLEN);

	// Address, row length and count writes all restart the cursor from
	// cfg_wdata, so software writes the address after the other two
	assign strb_wrcur = wr_hit && ((offset == `BLIT_REG_WRADDR) ||
	                               (offset == `BLIT_REG_WRROWL) ||
	                               (offset == `BLIT_REG_WRDONE));

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			row_len    <= '0;
			row_stride <= '0;
		end else begin
			if (wr_hit && (offset == `BLIT_REG_WRROWL))
				row_len <= cfg_wdata[`BLIT_ADDR_W-1:0];
			if (wr_hit && (offset == `BLIT_REG_WRROWS))
				row_stride <= cfg_wdata[`BLIT_ADDR_W-1:0];
		end
	end

	// Done strobe and read data one cycle after the access
	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			cfg_done  <= 1'b0;
			cfg_rdata <= '0;
		end else begin
			cfg_done <= hit;
			if (rd_hit && (offset == `BLIT_REG_WRDONE))
				cfg_rdata <= {{(32-`BLIT_ADDR_W){1'b0}}, wr_done};
			else
				cfg_rdata <= '0;
		end
	end

	a_done_single: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		cfg_done |=> !cfg_done);

endmodule

// ==== logic/fsab_credit_counter.sv ====
/* fsab_credit_counter: memory bus credit pool
 * Returns add, issued requests subtract
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module fsab_credit_counter (
	input  logic fsabi_clk,
	input  logic fsabi_rst_b,
	input  logic fsabo_credit,
	input  logic take,
	output logic credit_avail
);

	logic [`BLIT_CREDITS_W-1:0] credits;

	// Return and take may land in the same cycle
	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b)
			credits <= `BLIT_CREDITS_W'(`BLIT_INIT_CREDITS);
		else
			credits <= credits + `BLIT_CREDITS_W'(fsabo_credit) - `BLIT_CREDITS_W'(take);
	end

	assign credit_avail = (credits != '0);

	a_no_underflow: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		take |-> credit_avail);

	// More returns than requests issued means the bus model lost count
	a_no_overflow: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		(credits == `BLIT_CREDITS_W'(`BLIT_INIT_CREDITS)) |-> !(fsabo_credit && !take));

endmodule

// ==== logic/blit_seq_fsm.sv ====
/* blit_seq_fsm: per-packet sequencer
 * Read request, read collection, write burst
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module blit_seq_fsm (
	input  logic fsabi_clk,
	input  logic fsabi_rst_b,
	input  logic pkts_left,
	input  logic credit_avail,
	input  logic buf_full,
	input  logic buf_last,
	output logic take,
	output logic issue_rd,
	output logic issue_wr,
	output logic beat_out,
	output logic pkt_done
);

	import blit_pkg::*;

	seq_state_t state;
	seq_state_t state_nx;

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b)
			state <= seq_idle;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		case (state)
			seq_idle: begin
				if (pkts_left)
					state_nx = seq_rd_req;
			end
			seq_rd_req: begin
				// Length rewritten to zero before the request went out
				if (!pkts_left)
					state_nx = seq_idle;
				else if (credit_avail)
					state_nx = seq_rd_wait;
			end
			seq_rd_wait: begin
				if (buf_full)
					state_nx = seq_wr_req;
			end
			seq_wr_req: begin
				if (credit_avail)
					state_nx = seq_wr_burst;
			end
			seq_wr_burst: begin
				if (buf_last)
					state_nx = seq_idle;
			end
			default: state_nx = seq_idle;
		endcase
	end

	assign issue_rd = (state == seq_rd_req) && pkts_left && credit_avail;
	assign issue_wr = (state == seq_wr_req) && credit_avail;
	assign take     = issue_rd || issue_wr;
	assign beat_out = (state == seq_wr_burst);
	assign pkt_done = beat_out && buf_last;

	a_wr_when_full: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		issue_wr |-> buf_full);

	// A started burst runs a full packet of beats without a gap
	a_burst_len: assert property (@(posedge fsabi_clk) disable iff (!fsabi_rst_b)
		issue_wr |=> beat_out [*`BLIT_BURST] ##1 !beat_out);

endmodule

// ==== logic/blit_line_buffer.sv ====
/* blit_line_buffer: one-packet data buffer
 * Fill and drain pointers, full flag, write data and byte mask
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module blit_line_buffer (
	input  logic                   fsabi_clk,
	input  logic                   fsabi_rst_b,
	input  logic                   beat_in,
	input  blit_pkg::blit_word_t   beat_data,
	input  logic                   beat_out,
	output logic                   buf_full,
	output logic                   buf_last,
	output blit_pkg::blit_word_t   wr_data,
	output logic [`BLIT_MASK_W-1:0] wr_mask
);

	import blit_pkg::*;

	localparam int PTR_W = $clog2(`BLIT_BURST);

	blit_word_t       words [`BLIT_BURST];
	logic [PTR_W-1:0] fill_ptr;
	logic [PTR_W-1:0] drain_ptr;
	logic             fill;

	assign fill = beat_in && !buf_full;

	always_ff @(posedge fsabi_clk) begin
		if (fill)
			words[fill_ptr] <= beat_data;
	end

	// Pointers wrap back to zero at the end of each packet
	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			fill_ptr  <= '0;
			drain_ptr <= '0;
			buf_full  <= 1'b0;
		end else begin
			if (fill) begin
				fill_ptr <= fill_ptr + 1'b1;
				if (fill_ptr == PTR_W'(`BLIT_BURST-1))
					buf_full <= 1'b1;
			end
			if (beat_out) begin
				drain_ptr <= drain_ptr + 1'b1;
				if (buf_last)
					buf_full <= 1'b0;
			end
		end
	end

	assign buf_last = (drain_ptr == PTR_W'(`BLIT_BURST-1));
	assign wr_data  = words[drain_ptr];

	// Transparency bits, bit 0 for the upper bytes and bit 32 for the lower
	assign wr_mask = {{(`BLIT_MASK_W/2){wr_data[0]}},
	                  {(`BLIT_MASK_W/2){wr_data[`BLIT_DATA_W/2]}}};

endmodule

// ==== logic/blit_addr_gen.sv ====
/* blit_addr_gen: address generation
 * Read address and length, write cursor with row stepping,
 * written packet count
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module blit_addr_gen (
	input  logic                 fsabi_clk,
	input  logic                 fsabi_rst_b,
	input  logic                 strb_rdaddr,
	input  logic                 strb_rdlen,
	input  logic                 strb_wrcur,
	input  logic [31:0]          cfg_wdata,
	input  blit_pkg::blit_addr_t row_len,
	input  blit_pkg::blit_addr_t row_stride,
	input  logic                 issue_rd,
	input  logic                 pkt_done,
	output blit_pkg::blit_addr_t rd_addr,
	output blit_pkg::blit_addr_t wr_addr,
	output logic                 pkts_left,
	output blit_pkg::blit_addr_t wr_done
);

	import blit_pkg::*;

	localparam blit_addr_t PKT_BYTES = blit_addr_t'(`BLIT_BURST * 8);

	blit_addr_t rd_len;
	blit_addr_t row_base;
	blit_addr_t row_pos;
	blit_addr_t next_row;
	blit_addr_t wdata_addr;
	logic       row_end;

	assign wdata_addr = cfg_wdata[`BLIT_ADDR_W-1:0];
	assign next_row   = row_base + row_stride;
	// A zero row length behaves as one packet per row
	assign row_end    = ((row_pos + 1'b1) >= row_len);
	assign pkts_left  = (rd_len != '0);

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			rd_addr <= '0;
			rd_len  <= '0;
		end else begin
			if (strb_rdaddr)
				rd_addr <= wdata_addr;
			else if (issue_rd)
				rd_addr <= rd_addr + PKT_BYTES;

			if (strb_rdlen)
				rd_len <= wdata_addr;
			else if (issue_rd)
				rd_len <= rd_len - 1'b1;
		end
	end

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			wr_addr  <= '0;
			row_base <= '0;
			row_pos  <= '0;
			wr_done  <= '0;
		end else if (strb_wrcur) begin
			wr_addr  <= wdata_addr;
			row_base <= wdata_addr;
			row_pos  <= '0;
			wr_done  <= '0;
		end else if (pkt_done) begin
			wr_done <= wr_done + 1'b1;
			if (row_end) begin
				row_base <= next_row;
				wr_addr  <= next_row;
				row_pos  <= '0;
			end else begin
				wr_addr <= wr_addr + PKT_BYTES;
				row_pos <= row_pos + 1'b1;
			end
		end
	end

endmodule

// ==== logic/accel_blit.sv ====
/* accel_blit: blit accelerator top level
 * Register slave, sequencer, credit pool, packet buffer, address
 * generator and the registered memory bus request port
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module accel_blit (
	input  logic                    fsabi_clk,
	input  logic                    fsabi_rst_b,
	input  logic                    cfg_valid,
	input  logic                    cfg_r_nw,
	input  logic [23:0]             cfg_addr,
	input  logic [31:0]             cfg_wdata,
	output logic                    cfg_done,
	output logic [31:0]             cfg_rdata,
	output logic                    fsabo_valid,
	output blit_pkg::fsab_mode_t    fsabo_mode,
	output logic [3:0]              fsabo_did,
	output logic [3:0]              fsabo_subdid,
	output blit_pkg::blit_addr_t    fsabo_addr,
	output logic [`BLIT_LEN_W-1:0]  fsabo_len,
	output blit_pkg::blit_word_t    fsabo_data,
	output logic [`BLIT_MASK_W-1:0] fsabo_mask,
	input  logic                    fsabo_credit,
	input  logic                    fsabi_valid,
	input  logic [3:0]              fsabi_did,
	input  logic [3:0]              fsabi_subdid,
	input  blit_pkg::blit_word_t    fsabi_data
);

	import blit_pkg::*;

	logic                    strb_rdaddr;
	logic                    strb_rdlen;
	logic                    strb_wrcur;
	blit_addr_t              row_len;
	blit_addr_t              row_stride;
	blit_addr_t              rd_addr;
	blit_addr_t              wr_addr;
	blit_addr_t              wr_done;
	blit_addr_t              burst_addr;
	logic                    pkts_left;
	logic                    take;
	logic                    issue_rd;
	logic                    issue_wr;
	logic                    beat_out;
	logic                    pkt_done;
	logic                    buf_full;
	logic                    buf_last;
	logic                    credit_avail;
	logic                    beat_in;
	blit_word_t              wr_data;
	logic [`BLIT_MASK_W-1:0] wr_mask;

	// Inbound beats for this device only
	assign beat_in = fsabi_valid && (fsabi_did == `BLIT_DID) &&
	                 (fsabi_subdid == `BLIT_SUBDID);

	blit_regs blit_regs_i (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.cfg_valid   (cfg_valid),
		.cfg_r_nw    (cfg_r_nw),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.wr_done     (wr_done),
		.cfg_done    (cfg_done),
		.cfg_rdata   (cfg_rdata),
		.strb_rdaddr (strb_rdaddr),
		.strb_rdlen  (strb_rdlen),
		.strb_wrcur  (strb_wrcur),
		.row_len     (row_len),
		.row_stride  (row_stride)
	);

	fsab_credit_counter fsab_credit_counter_i (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.fsabo_credit (fsabo_credit),
		.take         (take),
		.credit_avail (credit_avail)
	);

	blit_seq_fsm blit_seq_fsm_i (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.pkts_left    (pkts_left),
		.credit_avail (credit_avail),
		.buf_full     (buf_full),
		.buf_last     (buf_last),
		.take         (take),
		.issue_rd     (issue_rd),
		.issue_wr     (issue_wr),
		.beat_out     (beat_out),
		.pkt_done     (pkt_done)
	);

	blit_line_buffer blit_line_buffer_i (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.beat_in     (beat_in),
		.beat_data   (fsabi_data),
		.beat_out    (beat_out),
		.buf_full    (buf_full),
		.buf_last    (buf_last),
		.wr_data     (wr_data),
		.wr_mask     (wr_mask)
	);

	blit_addr_gen blit_addr_gen_i (
		.fsabi_clk   (fsabi_clk),
		.fsabi_rst_b (fsabi_rst_b),
		.strb_rdaddr (strb_rdaddr),
		.strb_rdlen  (strb_rdlen),
		.strb_wrcur  (strb_wrcur),
		.cfg_wdata   (cfg_wdata),
		.row_len     (row_len),
		.row_stride  (row_stride),
		.issue_rd    (issue_rd),
		.pkt_done    (pkt_done),
		.rd_addr     (rd_addr),
		.wr_addr     (wr_addr),
		.pkts_left   (pkts_left),
		.wr_done     (wr_done)
	);

	always_ff @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b)
			fsabo_valid <= 1'b0;
		else
			fsabo_valid <= issue_rd || beat_out;
	end

	// Burst address held so a cursor reload cannot split a burst
	always_ff @(posedge fsabi_clk) begin
		if (issue_wr)
			burst_addr <= wr_addr;
		if (issue_rd || beat_out) begin
			fsabo_did    <= `BLIT_DID;
			fsabo_subdid <= `BLIT_SUBDID;
			fsabo_len    <= `BLIT_LEN_W'(`BLIT_BURST);
		end
		if (issue_rd) begin
			fsabo_mode <= fsab_read;
			fsabo_addr <= rd_addr;
		end else if (beat_out) begin
			fsabo_mode <= fsab_write;
			fsabo_addr <= burst_addr;
			fsabo_data <= wr_data;
			fsabo_mask <= wr_mask;
		end
	end

endmodule

// ==== test/blit_checker.sv ====
/* blit_checker: bus monitor and scoreboard
 * Predicts read requests, write bursts, byte masks, WRDONE readback
 * and outstanding credits, and counts errors
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module blit_checker (
	input  logic                    fsabi_clk,
	input  logic                    fsabi_rst_b,
	input  logic                    cfg_valid,
	input  logic                    cfg_r_nw,
	input  logic [23:0]             cfg_addr,
	input  logic [31:0]             cfg_wdata,
	input  logic                    cfg_done,
	input  logic [31:0]             cfg_rdata,
	input  logic                    fsabo_valid,
	input  blit_pkg::fsab_mode_t    fsabo_mode,
	input  logic [3:0]              fsabo_did,
	input  logic [3:0]              fsabo_subdid,
	input  blit_pkg::blit_addr_t    fsabo_addr,
	input  logic [`BLIT_LEN_W-1:0]  fsabo_len,
	input  blit_pkg::blit_word_t    fsabo_data,
	input  logic [`BLIT_MASK_W-1:0] fsabo_mask,
	input  logic                    fsabo_credit,
	input  logic [31:0]             exp_wr_done,
	output int                      errors,
	output int                      checks
);

	import blit_pkg::*;

	blit_addr_t rd_next;
	blit_addr_t rd_base;
	blit_addr_t burst_addr;
	blit_addr_t wr_cur;
	blit_addr_t row_base;
	blit_addr_t row_pos;
	blit_addr_t row_len;
	blit_addr_t row_stride;
	blit_addr_t rd_q [$];
	blit_word_t exp_word;
	logic [7:0] exp_mask;
	logic       hit;
	logic       hit_q;
	logic       rd_done_q;
	int         beat_idx;
	int         outstanding;

	// Memory contents: upper half a >> 4, lower half a >> 3
	function automatic blit_word_t expected_word(input blit_addr_t a);
		blit_word_t w;
		w[63:32] = 32'(a >> 4);
		w[31:0]  = 32'(a >> 3);
		return w;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	task automatic reload_cursor();
		wr_cur   = cfg_wdata[`BLIT_ADDR_W-1:0];
		row_base = cfg_wdata[`BLIT_ADDR_W-1:0];
		row_pos  = '0;
	endtask

	task automatic advance_cursor();
		if (row_pos + 1 >= row_len) begin
			row_base = row_base + row_stride;
			wr_cur   = row_base;
			row_pos  = '0;
		end else begin
			wr_cur  = wr_cur + 64;
			row_pos = row_pos + 1;
		end
	endtask

	task automatic check_read_request();
		if (beat_idx != 0)
			report_failure("Read request issued inside a write burst");
		check_value("fsabo_addr", fsabo_addr, rd_next);
		check_value("fsabo_len", fsabo_len, `BLIT_BURST);
		check_value("fsabo_did", fsabo_did, `BLIT_DID);
		check_value("fsabo_subdid", fsabo_subdid, `BLIT_SUBDID);
		rd_q.push_back(rd_next);
		rd_next = rd_next + 64;
		outstanding++;
	endtask

	task automatic check_write_beat();
		if (beat_idx == 0) begin
			if (rd_q.size() == 0) begin
				report_failure("Write burst with no read request before it");
				rd_base = '0;
			end else begin
				rd_base = rd_q.pop_front();
			end
			burst_addr = wr_cur;
			outstanding++;
		end
		check_value("fsabo_addr", fsabo_addr, burst_addr);
		check_value("fsabo_len", fsabo_len, `BLIT_BURST);
		check_value("fsabo_did", fsabo_did, `BLIT_DID);
		check_value("fsabo_subdid", fsabo_subdid, `BLIT_SUBDID);
		exp_word = expected_word(rd_base + blit_addr_t'(8 * beat_idx));
		// Bit 0 opens the upper four bytes, bit 32 the lower four
		exp_mask = 8'h00;
		if (exp_word[0])
			exp_mask = exp_mask | 8'hF0;
		if (exp_word[32])
			exp_mask = exp_mask | 8'h0F;
		check_value("fsabo_data", fsabo_data, exp_word);
		check_value("fsabo_mask", fsabo_mask, exp_mask);
		beat_idx++;
		if (beat_idx == `BLIT_BURST) begin
			beat_idx = 0;
			advance_cursor();
		end
	endtask

	task automatic track_reg_write();
		case (cfg_addr[4:0])
			`BLIT_REG_RDADDR: rd_next = cfg_wdata[`BLIT_ADDR_W-1:0];
			`BLIT_REG_WRROWL: begin
				row_len = cfg_wdata[`BLIT_ADDR_W-1:0];
				reload_cursor();
			end
			`BLIT_REG_WRROWS: row_stride = cfg_wdata[`BLIT_ADDR_W-1:0];
			`BLIT_REG_WRADDR, `BLIT_REG_WRDONE: reload_cursor();
			default: ;
		endcase
	endtask

	initial begin
		errors = 0;
		checks = 0;
	end

	always @(posedge fsabi_clk or negedge fsabi_rst_b) begin
		if (!fsabi_rst_b) begin
			rd_next     = '0;
			wr_cur      = '0;
			row_base    = '0;
			row_pos     = '0;
			row_len     = '0;
			row_stride  = '0;
			hit_q       = 1'b0;
			rd_done_q   = 1'b0;
			beat_idx    = 0;
			outstanding = 0;
			rd_q.delete();
		end else begin
			if (fsabo_credit)
				outstanding--;
			if (fsabo_valid && (fsabo_mode == fsab_read)) begin
				check_read_request();
			end else if (fsabo_valid) begin
				check_write_beat();
			end else if (beat_idx != 0) begin
				report_failure($sformatf("Write burst broke off after %0d beats", beat_idx));
				beat_idx = 0;
			end
			if (outstanding > `BLIT_INIT_CREDITS)
				report_failure($sformatf("%0d requests outstanding, more than the credits",
					outstanding));

			// One done strobe per register access, a cycle later
			if (cfg_done || hit_q)
				check_value("cfg_done", cfg_done, hit_q);
			if (rd_done_q)
				check_value("cfg_rdata", cfg_rdata, exp_wr_done);
			hit       = cfg_valid && ((cfg_addr & `BLIT_CFG_MASK) == `BLIT_CFG_PFX);
			hit_q     = hit;
			rd_done_q = hit && cfg_r_nw && (cfg_addr[4:0] == `BLIT_REG_WRDONE);
			if (hit && !cfg_r_nw)
				track_reg_write();
		end
	end

endmodule

// ==== test/tb_accel_blit.sv ====
/* tb_accel_blit: testbench top
 * Clock and reset, job table, memory and credit model, timeout
 */
`timescale 1ns/1ns
`include "blit_cfg.svh"

module tb_accel_blit;

	import blit_pkg::*;

	localparam int NJOBS = 4;

	logic                    fsabi_clk;
	logic                    fsabi_rst_b;
	logic                    cfg_valid;
	logic                    cfg_r_nw;
	logic [23:0]             cfg_addr;
	logic [31:0]             cfg_wdata;
	logic                    cfg_done;
	logic [31:0]             cfg_rdata;
	logic                    fsabo_valid;
	fsab_mode_t              fsabo_mode;
	logic [3:0]              fsabo_did;
	logic [3:0]              fsabo_subdid;
	blit_addr_t              fsabo_addr;
	logic [`BLIT_LEN_W-1:0]  fsabo_len;
	blit_word_t              fsabo_data;
	logic [`BLIT_MASK_W-1:0] fsabo_mask;
	logic                    fsabo_credit;
	logic                    fsabi_valid;
	logic [3:0]              fsabi_did;
	logic [3:0]              fsabi_subdid;
	blit_word_t              fsabi_data;
	logic [31:0]             exp_wr_done;
	int                      errors;
	int                      checks;

	// Columns: read address, read length, write address, row length,
	// stride, expected WRDONE
	logic [31:0] jobs [NJOBS][6];

	integer     seed;
	int         cycles = 0;
	int         limit;
	int         pkts_written;
	int         base_pkts;
	int         wr_beats;
	int         rsp_wait;
	int         rsp_pos;
	int         ci;
	logic       rsp_busy;
	logic       credit_hold;
	blit_addr_t rsp_addr;
	int         credit_due [$];

	accel_blit accel_blit_i (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.cfg_valid    (cfg_valid),
		.cfg_r_nw     (cfg_r_nw),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_done     (cfg_done),
		.cfg_rdata    (cfg_rdata),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.fsabi_valid  (fsabi_valid),
		.fsabi_did    (fsabi_did),
		.fsabi_subdid (fsabi_subdid),
		.fsabi_data   (fsabi_data)
	);

	blit_checker checker_i (
		.fsabi_clk    (fsabi_clk),
		.fsabi_rst_b  (fsabi_rst_b),
		.cfg_valid    (cfg_valid),
		.cfg_r_nw     (cfg_r_nw),
		.cfg_addr     (cfg_addr),
		.cfg_wdata    (cfg_wdata),
		.cfg_done     (cfg_done),
		.cfg_rdata    (cfg_rdata),
		.fsabo_valid  (fsabo_valid),
		.fsabo_mode   (fsabo_mode),
		.fsabo_did    (fsabo_did),
		.fsabo_subdid (fsabo_subdid),
		.fsabo_addr   (fsabo_addr),
		.fsabo_len    (fsabo_len),
		.fsabo_data   (fsabo_data),
		.fsabo_mask   (fsabo_mask),
		.fsabo_credit (fsabo_credit),
		.exp_wr_done  (exp_wr_done),
		.errors       (errors),
		.checks       (checks)
	);

	function automatic blit_word_t mem_word(input blit_addr_t a);
		logic [31:0] a32;
		a32 = {1'b0, a};
		return {a32 >> 4, a32 >> 3};
	endfunction

	task automatic reg_access(input logic r_nw, input logic [4:0] offset,
		input logic [31:0] data);
		@(posedge fsabi_clk);
		#10;
		cfg_valid = 1'b1;
		cfg_r_nw  = r_nw;
		cfg_addr  = `BLIT_CFG_PFX | 24'(offset);
		cfg_wdata = data;
		@(posedge fsabi_clk);
		#10;
		cfg_valid = 1'b0;
	endtask

	initial begin
		fsabi_clk = 1'b0;
		forever #50 fsabi_clk = ~fsabi_clk;
	end

	always @(posedge fsabi_clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: jobs not finished after %0d cycles", limit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Memory and credit model, sampled and driven 10 ns after the edge
	initial begin
		forever begin
			@(posedge fsabi_clk);
			#10;
			fsabi_valid  = 1'b0;
			fsabo_credit = 1'b0;
			if (rsp_busy) begin
				if (rsp_wait > 0) begin
					rsp_wait--;
				end else if (rsp_pos < 0) begin
					// Beat for another device, must be ignored
					fsabi_valid  = 1'b1;
					fsabi_did    = `BLIT_DID ^ 4'h5;
					fsabi_subdid = `BLIT_SUBDID;
					fsabi_data   = {$random(seed), $random(seed)};
					rsp_pos      = 0;
				end else begin
					fsabi_valid  = 1'b1;
					fsabi_did    = `BLIT_DID;
					fsabi_subdid = `BLIT_SUBDID;
					fsabi_data   = mem_word(rsp_addr + blit_addr_t'(8 * rsp_pos));
					rsp_pos++;
					if (rsp_pos == `BLIT_BURST)
						rsp_busy = 1'b0;
				end
			end
			if (fsabo_valid && ((fsabo_mode == fsab_read) || (wr_beats == 0)))
				credit_due.push_back(cycles + 1 + int'($unsigned($random(seed)) % 4));
			if (fsabo_valid && (fsabo_mode == fsab_read)) begin
				rsp_addr = fsabo_addr;
				rsp_wait = 1 + int'($unsigned($random(seed)) % 5);
				rsp_pos  = -1;
				rsp_busy = 1'b1;
			end else if (fsabo_valid) begin
				wr_beats = (wr_beats + 1) % `BLIT_BURST;
				if (wr_beats == 0)
					pkts_written++;
			end
			// At most one credit back per cycle
			if (!credit_hold) begin
				for (ci = 0; ci < credit_due.size(); ci++) begin
					if (credit_due[ci] <= cycles) begin
						fsabo_credit = 1'b1;
						credit_due.delete(ci);
						break;
					end
				end
			end
		end
	end

	initial begin
		jobs = '{
			'{32'h0000_1000, 32'd3, 32'h0002_0000, 32'd2, 32'h0000_0400, 32'd3},
			'{32'h0000_4040, 32'd5, 32'h0003_0000, 32'd3, 32'h0000_1000, 32'd5},
			'{32'h0000_8000, 32'd4, 32'h0004_0000, 32'd1, 32'h0000_0200, 32'd4},
			'{32'h0000_a000, 32'd2, 32'h0005_0000, 32'd4, 32'h0000_0800, 32'd2}
		};
		limit = 200;
		for (int n = 0; n < NJOBS; n++)
			limit += int'(jobs[n][1]) * 40;
		seed         = 32'hb585;
		fsabi_rst_b  = 1'b0;
		cfg_valid    = 1'b0;
		cfg_r_nw     = 1'b0;
		cfg_addr     = '0;
		cfg_wdata    = '0;
		fsabo_credit = 1'b0;
		fsabi_valid  = 1'b0;
		fsabi_did    = '0;
		fsabi_subdid = '0;
		fsabi_data   = '0;
		exp_wr_done  = '0;
		pkts_written = 0;
		wr_beats     = 0;
		rsp_busy     = 1'b0;
		credit_hold  = 1'b0;
		rsp_wait     = 0;
		rsp_pos      = 0;
		rsp_addr     = '0;
		repeat (4) @(posedge fsabi_clk);
		#10;
		fsabi_rst_b = 1'b1;

		for (int j = 0; j < NJOBS; j++) begin
			base_pkts = pkts_written;
			// Row length reloads the cursor too, so the write address goes last
			reg_access(1'b0, `BLIT_REG_RDADDR, jobs[j][0]);
			reg_access(1'b0, `BLIT_REG_WRROWL, jobs[j][3]);
			reg_access(1'b0, `BLIT_REG_WRROWS, jobs[j][4]);
			reg_access(1'b0, `BLIT_REG_WRADDR, jobs[j][2]);
			// Second job runs the credit pool dry before credits flow again
			credit_hold = (j == 1);
			reg_access(1'b0, `BLIT_REG_RDLEN, jobs[j][1]);
			if (j == 1) begin
				wait (pkts_written == base_pkts + 2);
				credit_hold = 1'b0;
			end
			wait (pkts_written == base_pkts + int'(jobs[j][1]));
			exp_wr_done = jobs[j][5];
			reg_access(1'b1, `BLIT_REG_WRDONE, 32'h0);
		end

		repeat (2) @(posedge fsabi_clk);
		#10;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+logic
logic/blit_pkg.sv
logic/blit_regs.sv
logic/fsab_credit_counter.sv
logic/blit_seq_fsm.sv
logic/blit_line_buffer.sv
logic/blit_addr_gen.sv
logic/accel_blit.sv
test/blit_checker.sv
test/tb_accel_blit.sv
